// File: design/rv32e_pkg.sv
////////////////////////////////////////////////////////////
// shared definitions for the RV32E integer core
// opcode and funct encodings, CSR addresses, the instruction
// union and the decode and retire records
// every design file refers to these by scoped name
////////////////////////////////////////////////////////////

`default_nettype none

package rv32e_pkg;

    localparam int gpr_num = 16;
    localparam int csr_num = 4;

    localparam logic [31:0] mstatus_reset = 32'h0000_1800;   // MPP = machine

    // major opcodes
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_system = 7'b1110011;

    // funct3, integer ops
    localparam logic [2:0] f3_add = 3'b000;   // add, sub, addi
    localparam logic [2:0] f3_sll = 3'b001;
    localparam logic [2:0] f3_slt = 3'b010;
    localparam logic [2:0] f3_xor = 3'b100;
    localparam logic [2:0] f3_srl = 3'b101;
    localparam logic [2:0] f3_or  = 3'b110;
    localparam logic [2:0] f3_and = 3'b111;

    // funct3, Zicsr
    localparam logic [2:0] f3_csrrw = 3'b001;
    localparam logic [2:0] f3_csrrs = 3'b010;

    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_alt  = 7'b0100000;   // sub

    localparam logic [11:0] csr_addr_mstatus = 12'h300;
    localparam logic [11:0] csr_addr_mtvec   = 12'h305;
    localparam logic [11:0] csr_addr_mepc    = 12'h341;
    localparam logic [11:0] csr_addr_mcause  = 12'h342;

    // slot of each CSR inside the register file
    localparam logic [1:0] csr_idx_mstatus = 2'd0;
    localparam logic [1:0] csr_idx_mtvec   = 2'd1;
    localparam logic [1:0] csr_idx_mepc    = 2'd2;
    localparam logic [1:0] csr_idx_mcause  = 2'd3;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor,
        alu_slt, alu_sll, alu_srl, alu_pass_b
    } alu_op_t;

    typedef enum logic [1:0] {csr_none, csr_rw, csr_set} csr_op_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_s;

    typedef struct packed {
        logic [11:0] imm12;   // also the CSR address
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_s;

    typedef union packed {
        r_fmt_s r;
        i_fmt_s i;
    } inst_u;

    typedef struct packed {
        logic [3:0]  rs1;
        logic [3:0]  rs2;
        logic [3:0]  rd;
        logic [31:0] imm;
        alu_op_t     alu_op;
        logic        use_imm;
        logic        gpr_we;
        csr_op_t     csr_op;
        logic [1:0]  csr_idx;
        logic        illegal;
    } dec_s;

    typedef struct packed {
        logic [3:0]  rd;
        logic [31:0] data;
        logic        gpr_we;
        logic        illegal;
    } retire_s;

endpackage

`default_nettype wire

// File: design/inst_decode.sv
////////////////////////////////////////////////////////////
// instruction decoder
// turns one instruction word into the decoded control record
// and flags anything outside the supported RV32E subset
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module inst_decode (
    input  rv32e_pkg::inst_u inst,
    output rv32e_pkg::dec_s  dec
);

    always_comb begin
        dec         = '0;
        dec.rs1     = inst.r.rs1[3:0];
        dec.rs2     = inst.r.rs2[3:0];
        dec.rd      = inst.r.rd[3:0];
        dec.alu_op  = rv32e_pkg::alu_add;
        dec.csr_op  = rv32e_pkg::csr_none;

        case (inst.r.opcode)
            rv32e_pkg::op_reg: begin
                dec.gpr_we = 1'b1;
                case ({inst.r.funct7, inst.r.funct3})
                    {rv32e_pkg::f7_base, rv32e_pkg::f3_add}: dec.alu_op = rv32e_pkg::alu_add;
                    {rv32e_pkg::f7_alt,  rv32e_pkg::f3_add}: dec.alu_op = rv32e_pkg::alu_sub;
                    {rv32e_pkg::f7_base, rv32e_pkg::f3_and}: dec.alu_op = rv32e_pkg::alu_and;
                    {rv32e_pkg::f7_base, rv32e_pkg::f3_or}:  dec.alu_op = rv32e_pkg::alu_or;
                    {rv32e_pkg::f7_base, rv32e_pkg::f3_xor}: dec.alu_op = rv32e_pkg::alu_xor;
                    {rv32e_pkg::f7_base, rv32e_pkg::f3_slt}: dec.alu_op = rv32e_pkg::alu_slt;
                    {rv32e_pkg::f7_base, rv32e_pkg::f3_sll}: dec.alu_op = rv32e_pkg::alu_sll;
                    {rv32e_pkg::f7_base, rv32e_pkg::f3_srl}: dec.alu_op = rv32e_pkg::alu_srl;
                    default: dec.illegal = 1'b1;   // sltu, sra, M ext
                endcase
                if (inst.r.rs1[4] || inst.r.rs2[4] || inst.r.rd[4])
                    dec.illegal = 1'b1;
            end
            rv32e_pkg::op_imm: begin
                dec.gpr_we  = 1'b1;
                dec.use_imm = 1'b1;
                dec.imm     = {{20{inst.i.imm12[11]}}, inst.i.imm12};
                case (inst.i.funct3)
                    rv32e_pkg::f3_add: dec.alu_op = rv32e_pkg::alu_add;
                    rv32e_pkg::f3_and: dec.alu_op = rv32e_pkg::alu_and;
                    rv32e_pkg::f3_or:  dec.alu_op = rv32e_pkg::alu_or;
                    rv32e_pkg::f3_xor: dec.alu_op = rv32e_pkg::alu_xor;
                    default: dec.illegal = 1'b1;
                endcase
                if (inst.i.rs1[4] || inst.i.rd[4])
                    dec.illegal = 1'b1;
            end
            rv32e_pkg::op_lui: begin
                dec.gpr_we  = 1'b1;
                dec.use_imm = 1'b1;
                dec.alu_op  = rv32e_pkg::alu_pass_b;
                dec.rs1     = 4'd0;   // upper bits are immediate here
                dec.imm     = {inst.i.imm12, inst.i.rs1, inst.i.funct3, 12'h000};
                if (inst.i.rd[4])
                    dec.illegal = 1'b1;
            end
            rv32e_pkg::op_system: begin
                dec.gpr_we = 1'b1;   // rd gets the old CSR value
                case (inst.i.funct3)
                    rv32e_pkg::f3_csrrw: dec.csr_op = rv32e_pkg::csr_rw;
                    rv32e_pkg::f3_csrrs: dec.csr_op = rv32e_pkg::csr_set;
                    default:             dec.illegal = 1'b1;   // ecall, ebreak, csr*i
                endcase
                case (inst.i.imm12)
                    rv32e_pkg::csr_addr_mstatus: dec.csr_idx = rv32e_pkg::csr_idx_mstatus;
                    rv32e_pkg::csr_addr_mtvec:   dec.csr_idx = rv32e_pkg::csr_idx_mtvec;
                    rv32e_pkg::csr_addr_mepc:    dec.csr_idx = rv32e_pkg::csr_idx_mepc;
                    rv32e_pkg::csr_addr_mcause:  dec.csr_idx = rv32e_pkg::csr_idx_mcause;
                    default:                     dec.illegal = 1'b1;
                endcase
                if (inst.i.rs1[4] || inst.i.rd[4])
                    dec.illegal = 1'b1;
            end
            default: dec.illegal = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

// File: design/reg_file.sv
////////////////////////////////////////////////////////////
// RV32E register file
// sixteen GPRs and the four machine CSRs, read combinationally
// and written on the rising clock edge
// x0 is never written so it always reads zero
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic [3:0]  rs1,
    input  wire logic [3:0]  rs2,
    input  wire logic [1:0]  csr_idx,
    output logic      [31:0] rs1_data,
    output logic      [31:0] rs2_data,
    output logic      [31:0] csr_data,
    input  wire logic        gpr_we,
    input  wire logic        csr_we,
    input  wire logic [3:0]  rd,
    input  wire logic [31:0] wdata,
    input  wire logic [31:0] csr_wdata,
    output logic             range_err
);

    logic [31:0] gpr [rv32e_pkg::gpr_num];
    logic [31:0] csr [rv32e_pkg::csr_num];   // mstatus, mtvec, mepc, mcause

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < rv32e_pkg::gpr_num; i++) begin
                gpr[i] <= 32'h0;
            end
            for (int i = 0; i < rv32e_pkg::csr_num; i++) begin
                csr[i] <= 32'h0;
            end
            csr[rv32e_pkg::csr_idx_mstatus] <= rv32e_pkg::mstatus_reset;
        end else begin
            if (gpr_we && rd != 4'd0) // x0 stays at zero
                gpr[rd] <= wdata;
            if (csr_we)
                csr[csr_idx] <= csr_wdata;
        end
    end

    assign rs1_data = gpr[rs1];
    assign rs2_data = gpr[rs2];
    assign csr_data = csr[csr_idx];

    // write aimed past the end of either array
    assign range_err = (gpr_we && int'(rd) >= rv32e_pkg::gpr_num) ||
                       (csr_we && int'(csr_idx) >= rv32e_pkg::csr_num);

endmodule

`default_nettype wire

// File: design/alu_execute.sv
////////////////////////////////////////////////////////////
// combinational ALU
// operand a is rs1, operand b is rs2 or the decoded immediate
// result feeds the result stage in the same cycle
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module alu_execute (
    input  rv32e_pkg::dec_s  dec,
    input  wire logic [31:0] rs1_data,
    input  wire logic [31:0] rs2_data,
    output logic      [31:0] alu_out
);

    logic [31:0] op_b;
    logic [4:0]  shamt;

    assign op_b  = dec.use_imm ? dec.imm : rs2_data;
    assign shamt = op_b[4:0];   // only low five bits count

    always_comb begin
        case (dec.alu_op)
            rv32e_pkg::alu_add:    alu_out = rs1_data + op_b;
            rv32e_pkg::alu_sub:    alu_out = rs1_data - op_b;
            rv32e_pkg::alu_and:    alu_out = rs1_data & op_b;
            rv32e_pkg::alu_or:     alu_out = rs1_data | op_b;
            rv32e_pkg::alu_xor:    alu_out = rs1_data ^ op_b;
            rv32e_pkg::alu_slt:    alu_out = {31'd0, $signed(rs1_data) < $signed(op_b)};
            rv32e_pkg::alu_sll:    alu_out = rs1_data << shamt;
            rv32e_pkg::alu_srl:    alu_out = rs1_data >> shamt;
            rv32e_pkg::alu_pass_b: alu_out = op_b;   // lui
            default:               alu_out = 32'h0;
        endcase
    end

endmodule

`default_nettype wire

// File: design/result_stage.sv
////////////////////////////////////////////////////////////
// result stage
// picks the rd data, builds the new CSR value, drives the
// register file write enables and registers the retire record
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module result_stage (
    input  wire logic         clk,
    input  wire logic         rst,
    input  wire logic         inst_valid,
    input  rv32e_pkg::dec_s   dec,
    input  wire logic [31:0]  alu_out,
    input  wire logic [31:0]  rs1_data,
    input  wire logic [31:0]  csr_data,
    input  wire logic         range_err,
    output logic              gpr_we,
    output logic              csr_we,
    output logic      [31:0]  wdata,
    output logic      [31:0]  csr_wdata,
    output logic              retire_valid,
    output rv32e_pkg::retire_s retire
);

    logic is_csr;
    logic commit;
    logic bad;

    assign is_csr = dec.csr_op != rv32e_pkg::csr_none;
    assign commit = inst_valid && !dec.illegal;

    assign gpr_we    = commit && dec.gpr_we;
    assign csr_we    = commit && is_csr;
    assign wdata     = is_csr ? csr_data : alu_out;   // CSR ops return the old value
    assign csr_wdata = (dec.csr_op == rv32e_pkg::csr_set) ? (csr_data | rs1_data) : rs1_data;

    assign bad = dec.illegal || range_err;

    always_ff @(posedge clk) begin
        if (rst) begin
            retire_valid   <= 1'b0;
            retire.gpr_we  <= 1'b0;
            retire.illegal <= 1'b0;
        end else begin
            retire_valid <= inst_valid;
            if (inst_valid) begin
                retire.gpr_we  <= gpr_we && !range_err;
                retire.illegal <= bad;
            end
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (inst_valid) begin
            retire.rd   <= dec.rd;
            retire.data <= bad ? 32'h0 : wdata;
        end
    end

endmodule

`default_nettype wire

// File: design/rv32e_core.sv
////////////////////////////////////////////////////////////
// top level of the RV32E integer core
// one instruction per cycle on inst_valid, result retired
// one cycle later on retire_valid, no back-pressure
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module rv32e_core (
    input  wire logic          clk,
    input  wire logic          rst,
    input  wire logic          inst_valid,
    input  rv32e_pkg::inst_u   inst,
    output logic               retire_valid,
    output rv32e_pkg::retire_s retire
);

    rv32e_pkg::dec_s dec;

    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic [31:0] csr_data;
    logic [31:0] alu_out;
    logic [31:0] wdata;
    logic [31:0] csr_wdata;
    logic        gpr_we;
    logic        csr_we;
    logic        range_err;

    inst_decode decode0 (
        .inst (inst),
        .dec  (dec)
    );

    reg_file regs0 (
        .clk       (clk),
        .rst       (rst),
        .rs1       (dec.rs1),
        .rs2       (dec.rs2),
        .csr_idx   (dec.csr_idx),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .csr_data  (csr_data),
        .gpr_we    (gpr_we),
        .csr_we    (csr_we),
        .rd        (dec.rd),
        .wdata     (wdata),
        .csr_wdata (csr_wdata),
        .range_err (range_err)
    );

    alu_execute alu0 (
        .dec      (dec),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .alu_out  (alu_out)
    );

    result_stage result0 (
        .clk          (clk),
        .rst          (rst),
        .inst_valid   (inst_valid),
        .dec          (dec),
        .alu_out      (alu_out),
        .rs1_data     (rs1_data),
        .csr_data     (csr_data),
        .range_err    (range_err),
        .gpr_we       (gpr_we),
        .csr_we       (csr_we),
        .wdata        (wdata),
        .csr_wdata    (csr_wdata),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

endmodule

`default_nettype wire

// File: tb/rv32e_core_sva.sv
////////////////////////////////////////////////////////////
// assertions on the retire interface of the RV32E core
// bound into every rv32e_core instance by the bind below
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module rv32e_core_sva (
    input wire logic          clk,
    input wire logic          rst,
    input wire logic          inst_valid,
    input wire logic          retire_valid,
    input rv32e_pkg::retire_s retire
);

    // quiet through reset and the first cycle out of it
    reset_quiet: assert property (@(posedge clk) rst |=> !retire_valid)
        else $error("retire_valid high after a reset cycle");

    follows_valid: assert property (@(posedge clk) !rst |=> retire_valid == $past(inst_valid))
        else $error("retire_valid does not follow inst_valid by one cycle");

    illegal_no_write: assert property (@(posedge clk) disable iff (rst)
        retire_valid && retire.illegal |-> !retire.gpr_we)
        else $error("illegal retire with gpr_we set");

endmodule

bind rv32e_core rv32e_core_sva sva0 (
    .clk          (clk),
    .rst          (rst),
    .inst_valid   (inst_valid),
    .retire_valid (retire_valid),
    .retire       (retire)
);

`default_nettype wire

// File: tb/rv32e_core_tb.sv
////////////////////////////////////////////////////////////
// testbench for the RV32E integer core
// directed reset, ALU, CSR, x0 and illegal cases, then an
// LCG driven instruction stream with random idle gaps
// every retire record is checked against a register mirror
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module rv32e_core_tb;

    localparam int wait_limit = 8;     // cycles allowed for one retire
    localparam int rand_count = 400;

    logic               clk;
    logic               rst;
    logic               inst_valid;
    logic        [31:0] inst;
    logic               retire_valid;
    rv32e_pkg::retire_s retire;

    logic [31:0] gpr_m [16];   // mirror of x0..x15
    logic [31:0] csr_m [4];    // mstatus, mtvec, mepc, mcause
    logic [31:0] rand_state;
    logic [15:0] gap;
    int          errors;
    int          checks;
    bit          hung;

    rv32e_core dut0 (
        .clk          (clk),
        .rst          (rst),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // upper half of the LCG state, the low bits cycle too fast
    function automatic logic [15:0] rand16();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state[31:16];
    endfunction

    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, rv32e_pkg::op_reg};
    endfunction

    function automatic logic [31:0] imm_word(input logic [11:0] imm, input logic [4:0] rs1,
                                             input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, rv32e_pkg::op_imm};
    endfunction

    function automatic logic [31:0] csr_word(input logic [11:0] addr, input logic [4:0] rs1,
                                             input logic [2:0] f3, input logic [4:0] rd);
        return {addr, rs1, f3, rd, rv32e_pkg::op_system};
    endfunction

    // reference model, works straight from the RV32I field layout
    task automatic predict(input logic [31:0] w, output rv32e_pkg::retire_s exp);
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [1:0]  slot;
        logic        bad;
        logic        is_csr;
        rd = w[11:7];
        rs1 = w[19:15];
        rs2 = w[24:20];
        f3 = w[14:12];
        a = gpr_m[rs1[3:0]];
        b = 32'h0;
        res = 32'h0;
        slot = 2'd0;
        is_csr = 1'b0;
        bad = rd[4] || rs1[4];
        case (w[6:0])
            rv32e_pkg::op_reg: begin
                bad = bad || rs2[4];
                b = gpr_m[rs2[3:0]];
                case ({w[31:25], f3})
                    {7'h00, 3'b000}: res = a + b;
                    {7'h20, 3'b000}: res = a - b;
                    {7'h00, 3'b111}: res = a & b;
                    {7'h00, 3'b110}: res = a | b;
                    {7'h00, 3'b100}: res = a ^ b;
                    {7'h00, 3'b010}: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    {7'h00, 3'b001}: res = a << b[4:0];
                    {7'h00, 3'b101}: res = a >> b[4:0];
                    default:         bad = 1'b1;
                endcase
            end
            rv32e_pkg::op_imm: begin
                b = {{20{w[31]}}, w[31:20]};
                case (f3)
                    3'b000:  res = a + b;
                    3'b111:  res = a & b;
                    3'b110:  res = a | b;
                    3'b100:  res = a ^ b;
                    default: bad = 1'b1;
                endcase
            end
            rv32e_pkg::op_lui: begin
                bad = rd[4];   // bits 19:15 belong to the immediate
                res = {w[31:12], 12'h000};
            end
            rv32e_pkg::op_system: begin
                is_csr = 1'b1;
                case (w[31:20])
                    rv32e_pkg::csr_addr_mstatus: slot = 2'd0;
                    rv32e_pkg::csr_addr_mtvec:   slot = 2'd1;
                    rv32e_pkg::csr_addr_mepc:    slot = 2'd2;
                    rv32e_pkg::csr_addr_mcause:  slot = 2'd3;
                    default:                     bad = 1'b1;
                endcase
                if (f3 != 3'b001 && f3 != 3'b010)
                    bad = 1'b1;
                res = csr_m[slot];   // old value goes to rd
            end
            default: bad = 1'b1;
        endcase
        if (!bad) begin
            if (is_csr)
                csr_m[slot] = (f3 == 3'b010) ? (res | a) : a;
            if (rd[3:0] != 4'd0)
                gpr_m[rd[3:0]] = res;
        end
        exp.rd = rd[3:0];
        exp.data = bad ? 32'h0 : res;
        exp.gpr_we = !bad;
        exp.illegal = bad;
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want, input logic [31:0] w);
        $display("Mismatch at %0t: %s got %h expected %h (inst %h)", $time, name, got, want, w);
        errors++;
    endtask

    // issue one instruction at a falling edge, then check its retire
    task automatic send(input logic [31:0] w);
        rv32e_pkg::retire_s exp;
        int waited;
        if (hung)
            return;
        predict(w, exp);
        inst = w;
        inst_valid = 1'b1;
        @(negedge clk);
        inst_valid = 1'b0;
        waited = 0;
        while (retire_valid !== 1'b1 && waited < wait_limit) begin
            @(negedge clk);
            waited++;
        end
        if (retire_valid !== 1'b1) begin
            $display("Timeout at %0t: instruction %h never retired", $time, w);
            errors++;
            hung = 1'b1;
        end else begin
            checks++;
            if (retire.rd !== exp.rd)
                report_mismatch("retire.rd", 32'(retire.rd), 32'(exp.rd), w);
            if (retire.data !== exp.data)
                report_mismatch("retire.data", retire.data, exp.data, w);
            if (retire.gpr_we !== exp.gpr_we)
                report_mismatch("retire.gpr_we", 32'(retire.gpr_we), 32'(exp.gpr_we), w);
            if (retire.illegal !== exp.illegal)
                report_mismatch("retire.illegal", 32'(retire.illegal), 32'(exp.illegal), w);
        end
    endtask

    // idle cycles with junk on inst, nothing may retire
    task automatic idle(input int n);
        for (int k = 0; k < n; k++) begin
            inst = {rand16(), rand16()};
            @(negedge clk);
            if (retire_valid !== 1'b0)
                report_mismatch("retire_valid", 32'(retire_valid), 32'h0, inst);
        end
    endtask

    function automatic logic [31:0] random_inst();
        logic [15:0] r;
        logic [15:0] s;
        logic [15:0] t;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [2:0]  f3;
        logic [11:0] addr;
        logic [31:0] w;
        r = rand16();
        s = rand16();
        t = rand16();
        rd = {1'b0, s[3:0]};
        rs1 = {1'b0, s[7:4]};
        case (r[1:0])
            2'd0:    f3 = 3'b000;
            2'd1:    f3 = 3'b100;
            2'd2:    f3 = 3'b110;
            default: f3 = 3'b111;
        endcase
        case (r[1:0])
            2'd0:    addr = rv32e_pkg::csr_addr_mstatus;
            2'd1:    addr = rv32e_pkg::csr_addr_mtvec;
            2'd2:    addr = rv32e_pkg::csr_addr_mepc;
            default: addr = rv32e_pkg::csr_addr_mcause;
        endcase
        case (r[15:12])
            4'd5, 4'd6, 4'd7: w = imm_word(t[11:0], rs1, f3, rd);
            4'd8, 4'd9:       w = {t, r[3:0], rd, rv32e_pkg::op_lui};
            4'd10, 4'd11:     w = csr_word(addr, rs1, r[2] ? 3'b010 : 3'b001, rd);
            4'd12: begin
                case (r[3:2])
                    2'd0:    w = r_word(7'h00, {1'b0, s[11:8]}, rs1, 3'b000, rd | 5'h10);
                    2'd1:    w = csr_word(12'h7c0, rs1, 3'b001, rd);   // not implemented
                    2'd2:    w = {t, s[15:7], 7'b0000011};              // load
                    default: w = imm_word(t[11:0], rs1 | 5'h10, 3'b000, rd);
                endcase
            end
            // sltu shows up now and then as an unknown funct
            default: w = r_word((r[3] && r[2:0] == 3'b000) ? 7'h20 : 7'h00,
                                {1'b0, s[11:8]}, rs1, r[2:0], rd);
        endcase
        return w;
    endfunction

    initial begin
        rand_state = 32'd60;
        errors = 0;
        checks = 0;
        hung = 1'b0;
        inst = 32'h0;
        inst_valid = 1'b0;
        rst = 1'b1;
        for (int k = 0; k < 16; k++)
            gpr_m[k] = 32'h0;
        csr_m[0] = 32'h0000_1800;
        csr_m[1] = 32'h0;
        csr_m[2] = 32'h0;
        csr_m[3] = 32'h0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        idle(2);

        // CSR reset values
        send(csr_word(rv32e_pkg::csr_addr_mstatus, 5'd0, 3'b010, 5'd1));
        send(csr_word(rv32e_pkg::csr_addr_mtvec, 5'd0, 3'b010, 5'd2));
        send(csr_word(rv32e_pkg::csr_addr_mepc, 5'd0, 3'b010, 5'd3));
        send(csr_word(rv32e_pkg::csr_addr_mcause, 5'd0, 3'b010, 5'd4));
        idle(1);
        // lui and a dependent chain, slt sign, shift amount above 31
        send({20'h80000, 5'd3, rv32e_pkg::op_lui});
        send(imm_word(12'hfff, 5'd3, 3'b000, 5'd3));
        send({20'hfffff, 5'd5, rv32e_pkg::op_lui});
        send(r_word(7'h00, 5'd3, 5'd5, 3'b010, 5'd6));
        send(r_word(7'h00, 5'd5, 5'd3, 3'b010, 5'd7));
        send(imm_word(12'h024, 5'd0, 3'b000, 5'd8));
        send(r_word(7'h00, 5'd8, 5'd5, 3'b101, 5'd9));
        send(r_word(7'h00, 5'd8, 5'd3, 3'b001, 5'd10));
        // csrrw then csrrs, read back
        send(csr_word(rv32e_pkg::csr_addr_mtvec, 5'd3, 3'b001, 5'd11));
        send(csr_word(rv32e_pkg::csr_addr_mtvec, 5'd0, 3'b010, 5'd12));
        send(csr_word(rv32e_pkg::csr_addr_mstatus, 5'd6, 3'b010, 5'd0));
        send(csr_word(rv32e_pkg::csr_addr_mstatus, 5'd0, 3'b010, 5'd13));
        // x0 as destination
        send(imm_word(12'h05a, 5'd0, 3'b000, 5'd0));
        send(r_word(7'h00, 5'd0, 5'd0, 3'b000, 5'd14));
        // illegal encodings
        send(r_word(7'h00, 5'd2, 5'd1, 3'b000, 5'd17));
        send(csr_word(12'h7c0, 5'd3, 3'b001, 5'd1));
        send({25'h0, 7'b0000011});
        send(r_word(7'h00, 5'd18, 5'd3, 3'b000, 5'd4));
        idle(2);

        for (int n = 0; n < rand_count && !hung; n++) begin
            send(random_inst());
            gap = rand16();
            if (gap[1:0] == 2'b00)
                idle(int'(gap[3:2]) + 1);
        end

        // final sweep through rd = x0, leaves all state alone
        for (int k = 0; k < 16; k++)
            send(imm_word(12'h000, 5'(k), 3'b000, 5'd0));
        send(csr_word(rv32e_pkg::csr_addr_mstatus, 5'd0, 3'b010, 5'd0));
        send(csr_word(rv32e_pkg::csr_addr_mtvec, 5'd0, 3'b010, 5'd0));
        send(csr_word(rv32e_pkg::csr_addr_mepc, 5'd0, 3'b010, 5'd0));
        send(csr_word(rv32e_pkg::csr_addr_mcause, 5'd0, 3'b010, 5'd0));
        idle(2);

        $display("retires checked %0d, errors %0d", checks, errors);
        if (errors == 0 && !hung) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rv32e_core.f
design/rv32e_pkg.sv
design/inst_decode.sv
design/reg_file.sv
design/alu_execute.sv
design/result_stage.sv
design/rv32e_core.sv
tb/rv32e_core_sva.sv
tb/rv32e_core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the RV32E core testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module rv32e_core_tb \
    -f rv32e_core.f -o rv32e_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/rv32e_sim > sim.log 2>&1
cat sim.log
grep -qx "TEST RESULT: PASS" sim.log && exit 0 || exit 1
